/* src/thresh_pkg.sv */
// Shared types for the sample threshold stream block
// Stream beats, settings bus, packet header, register maps and framer states
`default_nettype none

package thresh_pkg;

  ////////////////////////////////////////////////////////////
  // Bus and stream types
  ////////////////////////////////////////////////////////////

  // One word on a valid/ready stream
  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } stream_beat_t;

  // One write on the settings bus
  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } set_bus_t;

  // Fields of the outgoing two-word header
  typedef struct packed {
    logic [11:0] seqnum;
    logic [15:0] length;
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
  } pkt_hdr_t;

  ////////////////////////////////////////////////////////////
  // Register maps
  ////////////////////////////////////////////////////////////

  typedef enum logic [7:0] {
    SR_THRESHOLD = 8'd128,
    SR_SID       = 8'd129,
    SR_CLEAR     = 8'd130
  } sr_addr_e;

  typedef enum logic [7:0] {
    RB_THRESHOLD    = 8'd0,
    RB_SID          = 8'd1,
    RB_SAMPLES_IN   = 8'd2,
    RB_SAMPLES_KEPT = 8'd3
  } rb_addr_e;

  // Returned for any readback address not in the map
  localparam logic [63:0] RB_BAD = 64'h0BADC0DE_0BADC0DE;

  typedef enum logic [1:0] {
    S_IDLE,
    S_HDR0,
    S_HDR1,
    S_PAYLOAD
  } framer_state_e;

  // Word 0: seqnum in 27:16, length in 15:0
  function automatic logic [31:0] hdr_word0(input pkt_hdr_t h);
    return {4'd0, h.seqnum, h.length};
  endfunction

  // Word 1: destination SID high, source SID low
  function automatic logic [31:0] hdr_word1(input pkt_hdr_t h);
    return {h.dst_sid, h.src_sid};
  endfunction

endpackage

`default_nettype wire

/* src/settings_regs.sv */
// Settings registers for the threshold block
// Decodes settings writes and serves the combinational readback port
`timescale 1ns/1ns
`default_nettype none

module settings_regs (
  input  wire                      ce_clk,
  input  wire                      i_rst,
  // Settings bus
  input  wire thresh_pkg::set_bus_t i_set,
  // Readback
  input  wire thresh_pkg::rb_addr_e i_rb_addr,
  input  wire [31:0]               i_samples_in,
  input  wire [31:0]               i_samples_kept,
  // Register outputs
  output logic signed [31:0]       o_threshold,
  output logic [15:0]              o_src_sid,
  output logic [15:0]              o_dst_sid,
  output logic                     o_clear,
  output logic [63:0]              o_rb_data
);

  ////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_threshold <= '0;
      o_src_sid   <= '0;
      o_dst_sid   <= '0;
      o_clear     <= 1'b0;
    end else begin
      // Clear is a single-cycle pulse
      o_clear <= 1'b0;
      if (i_set.stb) begin
        case (i_set.addr)
          thresh_pkg::SR_THRESHOLD: begin
            o_threshold <= i_set.data;
          end
          thresh_pkg::SR_SID: begin
            o_src_sid <= i_set.data[15:0];
            o_dst_sid <= i_set.data[31:16];
          end
          // Data value is ignored
          thresh_pkg::SR_CLEAR: begin
            o_clear <= 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Readback mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (i_rb_addr)
      thresh_pkg::RB_THRESHOLD:    o_rb_data = {32'd0, o_threshold};
      thresh_pkg::RB_SID:          o_rb_data = {32'd0, o_dst_sid, o_src_sid};
      thresh_pkg::RB_SAMPLES_IN:   o_rb_data = {32'd0, i_samples_in};
      thresh_pkg::RB_SAMPLES_KEPT: o_rb_data = {32'd0, i_samples_kept};
      default:                     o_rb_data = thresh_pkg::RB_BAD;
    endcase
  end

endmodule

`default_nettype wire

/* src/sample_filter.sv */
// Threshold compare stage
// Registers each beat with a keep flag and counts input and kept samples
`timescale 1ns/1ns
`default_nettype none

module sample_filter (
  input  wire                          ce_clk,
  input  wire                          i_rst,
  input  wire signed [31:0]            i_threshold,
  // Input stream
  input  wire thresh_pkg::stream_beat_t i_beat,
  input  wire                          i_valid,
  output logic                         o_ready,
  // Kept-beat stream
  output thresh_pkg::stream_beat_t     o_beat,
  output logic                         o_keep,
  output logic                         o_valid,
  input  wire                          i_ready,
  // Counters for readback
  output logic [31:0]                  o_samples_in,
  output logic [31:0]                  o_samples_kept
);

  logic accept;
  logic keep_now;

  // Stage takes a beat when empty or draining this cycle
  assign o_ready  = !o_valid || i_ready;
  assign accept   = i_valid && o_ready;

  // Strictly greater, equal samples are dropped
  assign keep_now = $signed(i_beat.data) > i_threshold;

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else if (accept) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  // Beat and flag only matter while o_valid is high
  always_ff @(posedge ce_clk) begin
    if (accept) begin
      o_beat <= i_beat;
      o_keep <= keep_now;
    end
  end

  ////////////////////////////////////////////////////////////
  // Sample counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_samples_in   <= '0;
      o_samples_kept <= '0;
    end else if (accept) begin
      o_samples_in <= o_samples_in + 32'd1;
      if (keep_now) begin
        o_samples_kept <= o_samples_kept + 32'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/packet_buffer.sv */
// Payload buffer for filtered packets
// Stores kept samples and queues the length of each committed packet
`timescale 1ns/1ns
`default_nettype none

module packet_buffer #(
  parameter int BUF_DEPTH = 64,
  parameter int LEN_DEPTH = 4
) (
  input  wire                          ce_clk,
  input  wire                          i_rst,
  // Kept-beat stream from the filter
  input  wire thresh_pkg::stream_beat_t i_beat,
  input  wire                          i_keep,
  input  wire                          i_valid,
  output logic                         o_ready,
  // Length queue
  output logic [15:0]                  o_len,
  output logic                         o_len_valid,
  input  wire                          i_len_pop,
  // Payload stream
  output logic [31:0]                  o_pay_data,
  output logic                         o_pay_valid,
  input  wire                          i_pay_ready
);

  localparam int AW  = $clog2(BUF_DEPTH);
  localparam int LAW = (LEN_DEPTH > 1) ? $clog2(LEN_DEPTH) : 1;

  logic [31:0]    mem [BUF_DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  // Stored samples, and committed samples not yet read
  logic [AW:0]    fill;
  logic [AW:0]    avail;
  logic [15:0]    pkt_cnt;
  logic [15:0]    pkt_cnt_next;

  logic [15:0]    len_q [LEN_DEPTH];
  logic [LAW-1:0] lq_wr;
  logic [LAW-1:0] lq_rd;
  logic [LAW:0]   lq_count;

  logic           accept;
  logic           write;
  logic           read;
  logic           push;
  logic           pop;

  // Length queue depth need not be a power of two
  function automatic logic [LAW-1:0] lq_inc(input logic [LAW-1:0] p);
    return (p == LAW'(LEN_DEPTH - 1)) ? '0 : p + LAW'(1);
  endfunction

  assign o_ready      = (fill != (AW+1)'(BUF_DEPTH)) && (lq_count != (LAW+1)'(LEN_DEPTH));
  assign accept       = i_valid && o_ready;
  assign write        = accept && i_keep;
  assign pkt_cnt_next = pkt_cnt + {15'd0, i_keep};
  // Packets with nothing kept never reach the queue
  assign push         = accept && i_beat.last && (pkt_cnt_next != 16'd0);

  assign o_pay_valid  = (avail != '0);
  assign o_pay_data   = mem[rd_ptr];
  assign read         = o_pay_valid && i_pay_ready;

  assign o_len_valid  = (lq_count != '0);
  assign o_len        = len_q[lq_rd];
  assign pop          = i_len_pop && o_len_valid;

  ////////////////////////////////////////////////////////////
  // Sample memory
  ////////////////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (write) begin
      mem[wr_ptr] <= i_beat.data;
    end
    if (push) begin
      len_q[lq_wr] <= pkt_cnt_next;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      avail    <= '0;
      pkt_cnt  <= '0;
      lq_wr    <= '0;
      lq_rd    <= '0;
      lq_count <= '0;
    end else begin
      if (write) begin
        wr_ptr <= wr_ptr + AW'(1);
      end
      if (read) begin
        rd_ptr <= rd_ptr + AW'(1);
      end
      fill  <= fill + (AW+1)'(write) - (AW+1)'(read);
      avail <= avail + (push ? pkt_cnt_next[AW:0] : '0) - (AW+1)'(read);

      // Running count restarts after every last beat
      if (accept) begin
        pkt_cnt <= i_beat.last ? 16'd0 : pkt_cnt_next;
      end

      ////////////////////////////////////////////////////////////
      // Length queue
      ////////////////////////////////////////////////////////////
      if (push) begin
        lq_wr <= lq_inc(lq_wr);
      end
      if (pop) begin
        lq_rd <= lq_inc(lq_rd);
      end
      lq_count <= lq_count + (LAW+1)'(push) - (LAW+1)'(pop);
    end
  end

endmodule

`default_nettype wire

/* src/header_framer.sv */
// Packet framer
// Sends a two-word header and then the buffered payload of one packet
`timescale 1ns/1ns
`default_nettype none

module header_framer (
  input  wire                      ce_clk,
  input  wire                      i_rst,
  input  wire                      i_clear,
  input  wire [15:0]               i_src_sid,
  input  wire [15:0]               i_dst_sid,
  // Length queue
  input  wire [15:0]               i_len,
  input  wire                      i_len_valid,
  output logic                     o_len_pop,
  // Payload from the buffer
  input  wire [31:0]               i_pay_data,
  input  wire                      i_pay_valid,
  output logic                     o_pay_ready,
  // Output stream
  output thresh_pkg::stream_beat_t o_beat,
  output logic                     o_valid,
  input  wire                      i_ready
);

  thresh_pkg::framer_state_e state;
  thresh_pkg::pkt_hdr_t      hdr;
  logic [11:0]               seqnum;
  logic [15:0]               remain;
  logic                      start;
  logic                      in_payload;
  logic                      final_word;

  assign start       = (state == thresh_pkg::S_IDLE) && i_len_valid;
  assign in_payload  = (state == thresh_pkg::S_PAYLOAD);
  assign final_word  = (remain == 16'd1);
  assign o_pay_ready = in_payload && i_ready;
  assign o_len_pop   = in_payload && i_pay_valid && i_ready && final_word;

  always_comb begin
    o_beat  = '0;
    o_valid = 1'b0;
    case (state)
      thresh_pkg::S_HDR0: begin
        o_beat.data = thresh_pkg::hdr_word0(hdr);
        o_valid     = 1'b1;
      end
      thresh_pkg::S_HDR1: begin
        o_beat.data = thresh_pkg::hdr_word1(hdr);
        o_valid     = 1'b1;
      end
      thresh_pkg::S_PAYLOAD: begin
        o_beat.data = i_pay_data;
        o_beat.last = final_word;
        o_valid     = i_pay_valid;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      state  <= thresh_pkg::S_IDLE;
      seqnum <= '0;
    end else begin
      // A clear in the start cycle already applies to this header
      if (start) begin
        seqnum <= i_clear ? 12'd1 : seqnum + 12'd1;
      end else if (i_clear) begin
        seqnum <= '0;
      end
      case (state)
        thresh_pkg::S_IDLE:    if (i_len_valid) state <= thresh_pkg::S_HDR0;
        thresh_pkg::S_HDR0:    if (i_ready) state <= thresh_pkg::S_HDR1;
        thresh_pkg::S_HDR1:    if (i_ready) state <= thresh_pkg::S_PAYLOAD;
        thresh_pkg::S_PAYLOAD: if (o_len_pop) state <= thresh_pkg::S_IDLE;
        default:               state <= thresh_pkg::S_IDLE;
      endcase
    end
  end

  // Header fields and word count for the packet in flight
  always_ff @(posedge ce_clk) begin
    if (start) begin
      hdr.seqnum  <= i_clear ? 12'd0 : seqnum;
      hdr.length  <= i_len;
      hdr.src_sid <= i_src_sid;
      hdr.dst_sid <= i_dst_sid;
      remain      <= i_len;
    end else if (in_payload && i_pay_valid && i_ready) begin
      remain <= remain - 16'd1;
    end
  end

endmodule

`default_nettype wire

/* src/threshold_block.sv */
// Sample threshold stream block
// Filters signed samples against a threshold and reframes each packet
`timescale 1ns/1ns
`default_nettype none

module threshold_block #(
  parameter int BUF_DEPTH = 64,
  parameter int LEN_DEPTH = 4
) (
  input  wire                          ce_clk,
  input  wire                          i_rst,
  // Settings and readback
  input  wire thresh_pkg::set_bus_t     i_set,
  input  wire thresh_pkg::rb_addr_e     i_rb_addr,
  output wire [63:0]                   o_rb_data,
  // Input stream
  input  wire thresh_pkg::stream_beat_t i_in_beat,
  input  wire                          i_in_valid,
  output wire                          o_in_ready,
  // Output stream
  output wire thresh_pkg::stream_beat_t o_out_beat,
  output wire                          o_out_valid,
  input  wire                          i_out_ready
);

  wire signed [31:0]        threshold;
  wire [15:0]               src_sid;
  wire [15:0]               dst_sid;
  wire                      clear;
  wire [31:0]               samples_in;
  wire [31:0]               samples_kept;

  // Filter to buffer
  wire thresh_pkg::stream_beat_t kept_beat;
  wire                      kept_keep;
  wire                      kept_valid;
  wire                      kept_ready;

  // Buffer to framer
  wire [15:0]               len;
  wire                      len_valid;
  wire                      len_pop;
  wire [31:0]               pay_data;
  wire                      pay_valid;
  wire                      pay_ready;

  ////////////////////////////////////////////////////////////
  // Settings, filter, buffer and framer
  ////////////////////////////////////////////////////////////

  settings_regs u_settings (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_set(i_set), .i_rb_addr(i_rb_addr),
    .i_samples_in(samples_in), .i_samples_kept(samples_kept),
    .o_threshold(threshold), .o_src_sid(src_sid), .o_dst_sid(dst_sid),
    .o_clear(clear), .o_rb_data(o_rb_data));

  sample_filter u_filter (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_threshold(threshold),
    .i_beat(i_in_beat), .i_valid(i_in_valid), .o_ready(o_in_ready),
    .o_beat(kept_beat), .o_keep(kept_keep), .o_valid(kept_valid), .i_ready(kept_ready),
    .o_samples_in(samples_in), .o_samples_kept(samples_kept));

  packet_buffer #(
    .BUF_DEPTH(BUF_DEPTH),
    .LEN_DEPTH(LEN_DEPTH))
  u_buffer (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_beat(kept_beat), .i_keep(kept_keep), .i_valid(kept_valid), .o_ready(kept_ready),
    .o_len(len), .o_len_valid(len_valid), .i_len_pop(len_pop),
    .o_pay_data(pay_data), .o_pay_valid(pay_valid), .i_pay_ready(pay_ready));

  header_framer u_framer (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_clear(clear),
    .i_src_sid(src_sid), .i_dst_sid(dst_sid),
    .i_len(len), .i_len_valid(len_valid), .o_len_pop(len_pop),
    .i_pay_data(pay_data), .i_pay_valid(pay_valid), .o_pay_ready(pay_ready),
    .o_beat(o_out_beat), .o_valid(o_out_valid), .i_ready(i_out_ready));

endmodule

`default_nettype wire

/* test/threshold_checker.sv */
// Scoreboard for the threshold block
// Models filter and framer from observed traffic and compares the output
`timescale 1ns/1ns
`default_nettype none

module threshold_checker (
  input  wire                          ce_clk,
  input  wire                          i_rst,
  input  wire thresh_pkg::set_bus_t     i_set,
  input  wire thresh_pkg::rb_addr_e     i_rb_addr,
  input  wire [63:0]                   i_rb_data,
  input  wire thresh_pkg::stream_beat_t i_in_beat,
  input  wire                          i_in_valid,
  input  wire                          i_in_ready,
  input  wire thresh_pkg::stream_beat_t i_out_beat,
  input  wire                          i_out_valid,
  input  wire                          i_out_ready,
  output int                           o_pending,
  output int                           o_value_errs,
  output int                           o_other_errs
);

  logic signed [31:0]       thr;
  logic [15:0]              src_sid;
  logic [15:0]              dst_sid;
  logic [11:0]              seq;
  logic [31:0]              n_in;
  logic [31:0]              n_kept;
  logic [31:0]              cur_pkt [$];
  thresh_pkg::stream_beat_t exp_q [$];
  int                       exp_id [$];
  string                    names [64];
  int                       cur_id = 0;
  int                       cur_exp = -1;
  int                       stream_errs;
  int                       rb_errs;
  int                       word_id;
  thresh_pkg::stream_beat_t want;
  logic [63:0]              rb_want;

  assign o_value_errs = stream_errs + rb_errs;

  task automatic note_test(input int id, input string name, input int exp_kept);
    names[id] = name;
    cur_id    = id;
    cur_exp   = exp_kept;
  endtask

  // Header then payload, last only on the final payload word
  task automatic close_packet();
    int n;
    int i;
    n = cur_pkt.size();
    if (cur_exp >= 0 && n != cur_exp) begin
      $display("Fail %s: kept count expected %0d actual %0d", names[cur_id], cur_exp, n);
      stream_errs++;
    end
    if (n > 0) begin
      exp_q.push_back({4'd0, seq, 16'(n), 1'b0});
      exp_q.push_back({dst_sid, src_sid, 1'b0});
      exp_id.push_back(cur_id);
      exp_id.push_back(cur_id);
      for (i = 0; i < n; i++) begin
        exp_q.push_back({cur_pkt[i], i == n - 1});
        exp_id.push_back(cur_id);
      end
      seq = seq + 12'd1;
    end
    cur_pkt.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // Stream model and output compare
  ////////////////////////////////////////////////////////////

  always @(posedge ce_clk) begin
    if (i_rst) begin
      thr = '0;
      src_sid = '0;
      dst_sid = '0;
      seq = '0;
      n_in = '0;
      n_kept = '0;
      cur_pkt.delete();
      exp_q.delete();
      exp_id.delete();
      stream_errs = 0;
      o_other_errs = 0;
    end else begin
      if (i_in_valid && i_in_ready) begin
        n_in = n_in + 32'd1;
        if ($signed(i_in_beat.data) > thr) begin
          cur_pkt.push_back(i_in_beat.data);
          n_kept = n_kept + 32'd1;
        end
        if (i_in_beat.last) begin
          close_packet();
        end
      end
      if (i_out_valid && i_out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected output beat %h with no packet outstanding", i_out_beat.data);
          o_other_errs++;
        end else begin
          want = exp_q.pop_front();
          word_id = exp_id.pop_front();
          if (i_out_beat !== want) begin
            $display("Fail %s: output beat expected %h actual %h",
                     names[word_id], want, i_out_beat);
            stream_errs++;
          end
        end
      end
      // New settings apply to beats after this edge
      if (i_set.stb) begin
        case (i_set.addr)
          thresh_pkg::SR_THRESHOLD: thr = i_set.data;
          thresh_pkg::SR_SID: begin
            src_sid = i_set.data[15:0];
            dst_sid = i_set.data[31:16];
          end
          thresh_pkg::SR_CLEAR: seq = 12'd0;
          default: begin
          end
        endcase
      end
    end
    o_pending <= exp_q.size();
  end

  ////////////////////////////////////////////////////////////
  // Readback compare, sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge ce_clk) begin
    if (i_rst) begin
      rb_errs = 0;
    end else begin
      case (i_rb_addr)
        thresh_pkg::RB_THRESHOLD:    rb_want = {32'd0, thr};
        thresh_pkg::RB_SID:          rb_want = {32'd0, dst_sid, src_sid};
        thresh_pkg::RB_SAMPLES_IN:   rb_want = {32'd0, n_in};
        thresh_pkg::RB_SAMPLES_KEPT: rb_want = {32'd0, n_kept};
        default:                     rb_want = 64'h0BADC0DE_0BADC0DE;
      endcase
      if (i_rb_data !== rb_want) begin
        $display("Fail %s: readback at %h expected %h actual %h",
                 names[cur_id], i_rb_addr, rb_want, i_rb_data);
        rb_errs++;
      end
    end
  end

endmodule

`default_nettype wire

/* test/tb_threshold_block.sv */
// Testbench for the sample threshold stream block
// Applies a table of packets behind settings writes and reports error counts
`timescale 1ns/1ns
`default_nettype none

module tb_threshold_block;

  localparam int BUF_DEPTH = 16;
  localparam int LEN_DEPTH = 4;
  localparam int ROWS      = 9;

  // One table row, kept is 16'hffff where samples are random
  typedef struct packed {
    logic [31:0] thr;
    logic [31:0] sid;
    logic [15:0] len;
    logic [31:0] start;
    logic [31:0] step;
    logic        clear;
    logic        rand_rdy;
    logic        rand_data;
    logic [15:0] kept;
  } row_t;

  logic                     ce_clk;
  logic                     i_rst;
  thresh_pkg::set_bus_t     i_set;
  thresh_pkg::rb_addr_e     i_rb_addr;
  wire [63:0]               o_rb_data;
  thresh_pkg::stream_beat_t i_in_beat;
  logic                     i_in_valid;
  wire                      o_in_ready;
  thresh_pkg::stream_beat_t o_out_beat;
  wire                      o_out_valid;
  logic                     i_out_ready;

  int          pending;
  int          value_errs;
  int          other_errs;
  int          cycles;
  int          limit;
  int          seed;
  int          rdy_seed;
  logic        rand_ready;
  logic [2:0]  rb_step;
  logic [31:0] last_sid;
  row_t        rows [ROWS];
  string       names [ROWS];

  threshold_block #(
    .BUF_DEPTH(BUF_DEPTH),
    .LEN_DEPTH(LEN_DEPTH))
  UUT (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_set(i_set), .i_rb_addr(i_rb_addr),
    .o_rb_data(o_rb_data), .i_in_beat(i_in_beat), .i_in_valid(i_in_valid),
    .o_in_ready(o_in_ready), .o_out_beat(o_out_beat), .o_out_valid(o_out_valid),
    .i_out_ready(i_out_ready));

  threshold_checker u_checker (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_set(i_set), .i_rb_addr(i_rb_addr),
    .i_rb_data(o_rb_data), .i_in_beat(i_in_beat), .i_in_valid(i_in_valid),
    .i_in_ready(o_in_ready), .i_out_beat(o_out_beat), .i_out_valid(o_out_valid),
    .i_out_ready(i_out_ready), .o_pending(pending), .o_value_errs(value_errs),
    .o_other_errs(other_errs));

  initial begin
    ce_clk = 1'b0;
    forever #10 ce_clk = ~ce_clk;
  end

  ////////////////////////////////////////////////////////////
  // Free-running drivers
  ////////////////////////////////////////////////////////////

  // Output ready, random only in the back-pressure rows
  always @(posedge ce_clk) begin
    logic [31:0] rnd;
    rnd = $random(rdy_seed);
    i_out_ready <= rand_ready ? rnd[0] : 1'b1;
  end

  // Readback sweeps the map plus one unmapped address
  always @(posedge ce_clk) begin
    rb_step   <= (rb_step == 3'd4) ? 3'd0 : rb_step + 3'd1;
    i_rb_addr <= (rb_step == 3'd4) ? thresh_pkg::rb_addr_e'(8'h7f) :
                 thresh_pkg::rb_addr_e'({5'd0, rb_step});
  end

  always @(posedge ce_clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles with %0d output words still missing",
               cycles, pending);
      $display("Errors: %0d value mismatches, %0d other problems",
               value_errs, other_errs + 1);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    i_set <= {1'b1, addr, data};
    @(posedge ce_clk);
    i_set <= '0;
  endtask

  task automatic wait_drain();
    while (pending != 0) begin
      @(posedge ce_clk);
    end
  endtask

  task automatic run_row(input int r);
    row_t        row;
    logic [31:0] value;
    logic [31:0] data;
    logic        taken;
    int          i;
    row = rows[r];
    // Header SIDs and seqnum clear must not overtake queued packets
    if (row.clear || row.sid != last_sid) begin
      wait_drain();
    end
    rand_ready <= row.rand_rdy;
    write_setting(thresh_pkg::SR_THRESHOLD, row.thr);
    write_setting(thresh_pkg::SR_SID, row.sid);
    if (row.clear) begin
      write_setting(thresh_pkg::SR_CLEAR, 32'd0);
    end
    last_sid = row.sid;
    u_checker.note_test(r, names[r], (row.kept == 16'hffff) ? -1 : int'(row.kept));
    value = row.start;
    for (i = 0; i < int'(row.len); i++) begin
      data = row.rand_data ? $random(seed) : value;
      i_in_beat  <= {data, i == int'(row.len) - 1};
      i_in_valid <= 1'b1;
      value = value + row.step;
      // Ready is stable mid-cycle and decides the transfer at the next edge
      do begin
        @(negedge ce_clk);
        taken = o_in_ready;
        @(posedge ce_clk);
      end while (!taken);
    end
    i_in_valid <= 1'b0;
    @(posedge ce_clk);
  endtask

  initial begin
    int r;
    seed        = 32'h58d2;
    rdy_seed    = 32'h58d2;
    i_rst       = 1'b1;
    i_set       = '0;
    i_rb_addr   = thresh_pkg::RB_THRESHOLD;
    i_in_beat   = '0;
    i_in_valid  = 1'b0;
    i_out_ready = 1'b1;
    rand_ready  = 1'b0;
    rb_step     = 3'd0;
    last_sid    = 32'd0;
    cycles      = 0;

    // thr, {dst,src}, len, start, step, {clear,rand_rdy,rand_data}, kept
    rows[0] = {32'd0, 32'h0020_0010, 16'd12, -32'd5, 32'd1, 3'b000, 16'd6};
    rows[1] = {-32'd3, 32'h0020_0010, 16'd8, -32'd6, 32'd1, 3'b000, 16'd4};
    rows[2] = {32'd100, 32'h0020_0010, 16'd6, 32'd100, 32'd0, 3'b000, 16'd0};
    rows[3] = {32'd100, 32'h0020_0010, 16'd5, 32'd98, 32'd1, 3'b000, 16'd2};
    rows[4] = {-32'd1000, 32'habcd_1234, 16'd10, -32'd2000, 32'd300, 3'b100, 16'd6};
    rows[5] = {32'd0, 32'habcd_1234, 16'd16, 32'd0, 32'd0, 3'b011, 16'hffff};
    rows[6] = {32'h4000_0000, 32'habcd_1234, 16'd16, 32'd0, 32'd0, 3'b011, 16'hffff};
    rows[7] = {32'h8000_0000, 32'habcd_1234, 16'd16, 32'd1, 32'd7, 3'b010, 16'd16};
    rows[8] = {32'd5, 32'habcd_1234, 16'd3, 32'd4, 32'd1, 3'b010, 16'd1};
    names = '{"ramp_pos", "neg_thresh", "equal_drop", "after_empty", "clear_seq",
              "bp_rand_a", "bp_rand_b", "bp_full", "bp_tail"};

    limit = 500;
    for (r = 0; r < ROWS; r++) begin
      limit += (int'(rows[r].len) + 4) * 4;
    end

    repeat (16) @(posedge ce_clk);
    i_rst <= 1'b0;
    @(posedge ce_clk);
    for (r = 0; r < ROWS; r++) begin
      run_row(r);
    end
    wait_drain();
    repeat (4) @(posedge ce_clk);

    $display("Errors: %0d value mismatches, %0d other problems", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
src/thresh_pkg.sv
src/settings_regs.sv
src/sample_filter.sv
src/packet_buffer.sv
src/header_framer.sv
src/threshold_block.sv
test/threshold_checker.sv
test/tb_threshold_block.sv

/* Bender.yml */
package:
  name: threshold_block

sources:
  - files:
      - src/thresh_pkg.sv
      - src/settings_regs.sv
      - src/sample_filter.sv
      - src/packet_buffer.sv
      - src/header_framer.sv
      - src/threshold_block.sv
  - target: test
    files:
      - test/threshold_checker.sv
      - test/tb_threshold_block.sv

# Top levels: threshold_block (design), tb_threshold_block (simulation)
